// File: core_cfg.svh
// widths are fixed for one 16-bit bus master with 11 address bits and 8-bit setting addresses
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// host bus
`define WB_AW          11    // address bits seen by the core
`define WB_DW          16    // data bits per transfer

// settings bus, two bus writes per setting
`define SET_AW         8
`define SET_DW         32

`define DECODE_W       4     // top address bits that pick a slave

// compatibility number, bump when the register map changes
`define COMPAT_MAJOR   9
`define COMPAT_MINOR   3

`define CGEN_CTRL_RST  3     // sync_b and ref_sel both high out of reset

`endif

// File: bus_pkg.sv
// types follow core_cfg.svh; the slave select only knows the three slaves kept in this core
`default_nettype none
`include "core_cfg.svh"

package bus_pkg;

   typedef logic [`WB_AW-1:0]  wb_adr_t;
   typedef logic [`WB_DW-1:0]  wb_dat_t;

   typedef logic [`SET_AW-1:0] set_addr_t;
   typedef logic [`SET_DW-1:0] set_data_t;

   typedef logic [63:0]        vita_time_t;   // ticks of wb_clk

   // one entry per decoded slave, SEL_NONE covers the unused slots
   typedef enum logic [1:0] {SEL_MISC, SEL_READBACK, SEL_SETTINGS, SEL_NONE} slave_sel_e;

endpackage

`default_nettype wire

// File: regmap_pkg.sv
// register map of the kept slaves only; setting addresses must fit the 8-bit setting address
`default_nettype none

package regmap_pkg;

   ///////////////////////////////////////////////////////////////////////
   // settings bus addresses
   typedef enum bus_pkg::set_addr_t
   {
      SR_TIME_HI    = 8'd42,   // upper time word, held until the low word
      SR_TIME_LO    = 8'd43,   // lower time word, loads the timer
      SR_REG_TEST32 = 8'd60
   } setting_addr_e;

   ///////////////////////////////////////////////////////////////////////
   // misc slave, offsets in address bits 6..0
   typedef enum logic [6:0]
   {
      REG_CGEN_CTRL = 7'd4,
      REG_CGEN_ST   = 7'd6,
      REG_TEST      = 7'd8
   } misc_reg_e;

   ///////////////////////////////////////////////////////////////////////
   // readback words, index in address bits 5..2; gaps read zero
   typedef enum logic [3:0]
   {
      RB_TIME_HI = 4'd0,
      RB_TIME_LO = 4'd1,
      RB_PPS_HI  = 4'd2,
      RB_PPS_LO  = 4'd3,
      RB_TEST32  = 4'd4,
      RB_COMPAT  = 4'd6
   } rb_word_e;

endpackage

`default_nettype wire

// File: wb_if.sv
// purely combinational channel; a slave on it must ack in the same cycle as its stb
`timescale 1ns/10ps
`default_nettype none

interface wb_if;

   bus_pkg::wb_adr_t adr;
   bus_pkg::wb_dat_t dat_w;
   logic             we;
   logic             stb;     // already qualified with cyc and slave select
   logic             ack;
   bus_pkg::wb_dat_t dat_r;

   // decoder side
   modport decoder
   (
      output adr, dat_w, we, stb,
      input  ack, dat_r
   );

   // slave side
   modport slave
   (
      input  adr, dat_w, we, stb,
      output ack, dat_r
   );

endinterface

`default_nettype wire

// File: wb_decode.sv
// single master, no back-pressure; unselected address slots never ack, so a master must time out
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module wb_decode
(
   input  wire bus_pkg::wb_adr_t wb_adr_i,
   input  wire bus_pkg::wb_dat_t wb_dat_i,
   input  wire                   wb_we_i,
   input  wire                   wb_stb_i,
   input  wire                   wb_cyc_i,
   output bus_pkg::wb_dat_t      wb_dat_o,
   output logic                  wb_ack_o,
   wb_if.decoder                 misc_bus,
   wb_if.decoder                 rb_bus,
   wb_if.decoder                 set_bus
);

   bus_pkg::slave_sel_e  sel;
   logic [`DECODE_W-1:0] dec;   // top address bits
   logic                 req;

   assign dec = wb_adr_i[`WB_AW-1 -: `DECODE_W];
   assign req = wb_stb_i & wb_cyc_i;

   always_comb
   begin
      if (dec[`DECODE_W-1])
         sel = bus_pkg::SEL_SETTINGS;   // 8 to f all land on the settings bus
      else if (dec == 4'h0)
         sel = bus_pkg::SEL_MISC;
      else if (dec == 4'h7)
         sel = bus_pkg::SEL_READBACK;
      else
         sel = bus_pkg::SEL_NONE;
   end

   ///////////////////////////////////////////////////////////////////////
   // address and write data go to every slave, strobe only to one
   assign misc_bus.adr   = wb_adr_i;
   assign misc_bus.dat_w = wb_dat_i;
   assign misc_bus.we    = wb_we_i;
   assign misc_bus.stb   = req & (sel == bus_pkg::SEL_MISC);

   assign rb_bus.adr     = wb_adr_i;
   assign rb_bus.dat_w   = wb_dat_i;
   assign rb_bus.we      = wb_we_i;
   assign rb_bus.stb     = req & (sel == bus_pkg::SEL_READBACK);

   assign set_bus.adr    = wb_adr_i;
   assign set_bus.dat_w  = wb_dat_i;
   assign set_bus.we     = wb_we_i;
   assign set_bus.stb    = req & (sel == bus_pkg::SEL_SETTINGS);

   // return path
   always_comb
   begin
      case (sel)
         bus_pkg::SEL_MISC:
         begin
            wb_ack_o = misc_bus.ack;
            wb_dat_o = misc_bus.dat_r;
         end
         bus_pkg::SEL_READBACK:
         begin
            wb_ack_o = rb_bus.ack;
            wb_dat_o = rb_bus.dat_r;
         end
         bus_pkg::SEL_SETTINGS:
         begin
            wb_ack_o = set_bus.ack;
            wb_dat_o = set_bus.dat_r;
         end
         default:
         begin
            wb_ack_o = 1'b0;            // empty slot, no ack
            wb_dat_o = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: misc_regs.sv
// clock-generator status inputs are read as-is and must already be stable in the wb_clk domain
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module misc_regs
(
   input  wire  wb_clk,
   input  wire  wb_rst,
   wb_if.slave  bus,
   input  wire  cgen_st_status_i,
   input  wire  cgen_st_ld_i,
   input  wire  cgen_st_refmon_i,
   output logic cgen_sync_b_o,
   output logic cgen_ref_sel_o
);

   bus_pkg::wb_dat_t reg_cgen_ctrl;   // bit 1 sync_b, bit 0 ref_sel
   bus_pkg::wb_dat_t reg_test;
   logic [6:0]       offs;

   assign offs    = bus.adr[6:0];
   assign bus.ack = bus.stb;          // zero wait state

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_cgen_ctrl <= bus_pkg::wb_dat_t'(`CGEN_CTRL_RST);
         reg_test      <= '0;
      end
      else if (bus.stb && bus.we)
      begin
         case (offs)
            regmap_pkg::REG_CGEN_CTRL: reg_cgen_ctrl <= bus.dat_w;
            regmap_pkg::REG_TEST:      reg_test      <= bus.dat_w;
            default:                   ;   // other offsets ignore writes
         endcase
      end
   end

   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];

   // read side
   always_comb
   begin
      case (offs)
         regmap_pkg::REG_CGEN_CTRL: bus.dat_r = reg_cgen_ctrl;
         regmap_pkg::REG_CGEN_ST:
            bus.dat_r = {{(`WB_DW-3){1'b0}}, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         regmap_pkg::REG_TEST:      bus.dat_r = reg_test;
         default:                   bus.dat_r = 16'hBEEF;   // marks an unmapped offset
      endcase
   end

endmodule

`default_nettype wire

// File: settings_bus.sv
// write the low half first, the high half fires the setting; reads return zero and set_stb lasts one cycle
`timescale 1ns/10ps
`default_nettype none

module settings_bus
(
   input  wire                  wb_clk,
   input  wire                  wb_rst,
   wb_if.slave                  bus,
   output logic                 set_stb_o,
   output bus_pkg::set_addr_t   set_addr_o,
   output bus_pkg::set_data_t   set_data_o
);

   bus_pkg::wb_dat_t lo_q;    // low half waiting for its high half
   logic             wr_lo;
   logic             wr_hi;

   assign bus.ack   = bus.stb;
   assign bus.dat_r = '0;     // write-only slave

   assign wr_lo = bus.stb & bus.we & ~bus.adr[1];
   assign wr_hi = bus.stb & bus.we &  bus.adr[1];

   always_ff @(posedge wb_clk)
   begin
      if (wr_lo)
         lo_q <= bus.dat_w;
   end

   // strobe is the only control state here
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_hi;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_hi)
      begin
         set_addr_o <= bus.adr[9:2];          // one setting per 4 byte addresses
         set_data_o <= {bus.dat_w, lo_q};     // little endian pair
      end
   end

endmodule

`default_nettype wire

// File: vita_timer.sv
// a time load acts at once (no wait for pps); the pps latch lags pps_i by three wb_clk edges
`timescale 1ns/10ps
`default_nettype none

module vita_timer
(
   input  wire                        wb_clk,
   input  wire                        wb_rst,
   input  wire                        set_stb_i,
   input  wire bus_pkg::set_addr_t    set_addr_i,
   input  wire bus_pkg::set_data_t    set_data_i,
   input  wire                        pps_i,
   output bus_pkg::vita_time_t        vita_time_o,
   output bus_pkg::vita_time_t        vita_time_pps_o
);

   bus_pkg::set_data_t time_hi_q;   // upper word, used on the next low-word load
   logic [2:0]         pps_sync;    // two sync flops, then the previous value
   logic               pps_edge;
   logic               ld_hi;
   logic               ld_lo;

   assign ld_hi = set_stb_i && (set_addr_i == regmap_pkg::SR_TIME_HI);
   assign ld_lo = set_stb_i && (set_addr_i == regmap_pkg::SR_TIME_LO);

   always_ff @(posedge wb_clk)
   begin
      if (ld_hi)
         time_hi_q <= set_data_i;
   end

   ///////////////////////////////////////////////////////////////////////
   // free-running time
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         vita_time_o <= '0;
      else if (ld_lo)
         vita_time_o <= {time_hi_q, set_data_i};
      else
         vita_time_o <= vita_time_o + 64'd1;
   end

   ///////////////////////////////////////////////////////////////////////
   // pps synchronizer and rising edge
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_sync <= '0;
         pps_edge <= 1'b0;
      end
      else
      begin
         pps_sync <= {pps_sync[1:0], pps_i};
         pps_edge <= pps_sync[1] & ~pps_sync[2];   // one pulse per rising edge
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (pps_edge)
         vita_time_pps_o <= vita_time_o;   // held until the next pps
   end

endmodule

`default_nettype wire

// File: readback_mux.sv
// read the low half first, it latches the word; a high half read alone returns the last latched word
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module readback_mux
(
   input  wire                        wb_clk,
   input  wire                        wb_rst,
   wb_if.slave                        bus,
   input  wire                        set_stb_i,
   input  wire bus_pkg::set_addr_t    set_addr_i,
   input  wire bus_pkg::set_data_t    set_data_i,
   input  wire bus_pkg::vita_time_t   vita_time_i,
   input  wire bus_pkg::vita_time_t   vita_time_pps_i
);

   bus_pkg::set_data_t reg_test32;
   bus_pkg::set_data_t compat;       // major high, minor low
   bus_pkg::set_data_t word_sel;
   bus_pkg::set_data_t word_hold;    // keeps both halves of one word coherent

   assign compat = {bus_pkg::wb_dat_t'(`COMPAT_MAJOR), bus_pkg::wb_dat_t'(`COMPAT_MINOR)};

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         reg_test32 <= '0;
      else if (set_stb_i && (set_addr_i == regmap_pkg::SR_REG_TEST32))
         reg_test32 <= set_data_i;
   end

   always_comb
   begin
      case (bus.adr[5:2])
         regmap_pkg::RB_TIME_HI: word_sel = vita_time_i[63:32];
         regmap_pkg::RB_TIME_LO: word_sel = vita_time_i[31:0];
         regmap_pkg::RB_PPS_HI:  word_sel = vita_time_pps_i[63:32];
         regmap_pkg::RB_PPS_LO:  word_sel = vita_time_pps_i[31:0];
         regmap_pkg::RB_TEST32:  word_sel = reg_test32;
         regmap_pkg::RB_COMPAT:  word_sel = compat;
         default:                word_sel = '0;
      endcase
   end

   always_ff @(posedge wb_clk)
   begin
      if (bus.stb && !bus.we && !bus.adr[1])
         word_hold <= word_sel;
   end

   assign bus.ack   = bus.stb;
   assign bus.dat_r = bus.adr[1] ? word_hold[31:16] : word_sel[15:0];

endmodule

`default_nettype wire

// File: u1_core.sv
// register side only, all in wb_clk; pps_i may be asynchronous, the status inputs must not be
`timescale 1ns/10ps
`default_nettype none

module u1_core
(
   input  wire                   wb_clk,
   input  wire                   wb_rst,
   // host bus
   input  wire bus_pkg::wb_adr_t wb_adr_i,
   input  wire bus_pkg::wb_dat_t wb_dat_i,
   input  wire                   wb_we_i,
   input  wire                   wb_stb_i,
   input  wire                   wb_cyc_i,
   output bus_pkg::wb_dat_t      wb_dat_o,
   output logic                  wb_ack_o,
   // clock generator
   input  wire                   cgen_st_status_i,
   input  wire                   cgen_st_ld_i,
   input  wire                   cgen_st_refmon_i,
   output logic                  cgen_sync_b_o,
   output logic                  cgen_ref_sel_o,
   input  wire                   pps_i
);

   logic                set_stb;
   bus_pkg::set_addr_t  set_addr;
   bus_pkg::set_data_t  set_data;
   bus_pkg::vita_time_t vita_time;
   bus_pkg::vita_time_t vita_time_pps;

   wb_if misc_bus ();   // slot 0
   wb_if rb_bus   ();   // slot 7
   wb_if set_bus  ();   // slots 8 to f

   wb_decode u_decode
   (
      .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_we_i  (wb_we_i),
      .wb_stb_i (wb_stb_i), .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
      .misc_bus (misc_bus), .rb_bus   (rb_bus),   .set_bus  (set_bus)
   );

   misc_regs u_misc
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (misc_bus),
      .cgen_st_status_i (cgen_st_status_i), .cgen_st_ld_i (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i),
      .cgen_sync_b_o    (cgen_sync_b_o),    .cgen_ref_sel_o (cgen_ref_sel_o)
   );

   settings_bus u_settings
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (set_bus),
      .set_stb_o (set_stb), .set_addr_o (set_addr), .set_data_o (set_data)
   );

   readback_mux u_readback
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst), .bus (rb_bus),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .vita_time_i (vita_time), .vita_time_pps_i (vita_time_pps)
   );

   vita_timer u_timer
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .set_stb_i (set_stb), .set_addr_i (set_addr), .set_data_i (set_data),
      .pps_i (pps_i),
      .vita_time_o (vita_time), .vita_time_pps_o (vita_time_pps)
   );

endmodule

`default_nettype wire

// File: tb_u1_core.sv
// one bus master, one transfer per cycle; all checks stop at the first mismatch, pps_i is driven in wb_clk
`timescale 1ns/10ps
`default_nettype none
`include "core_cfg.svh"

module tb_u1_core;

   localparam int CLK_PERIOD = 100;
   localparam int N_ITER     = 8;     // rounds per random test
   // reset 3, per round misc 6 + settings 4 + unused 2 + timer 10, compat 2, pps about 40
   localparam int N_XFERS    = 3 + N_ITER * (6 + 4 + 2 + 10) + 2 + 40;

   logic             wb_clk;
   logic             wb_rst;
   bus_pkg::wb_adr_t wb_adr_i;
   bus_pkg::wb_dat_t wb_dat_i;
   logic             wb_we_i;
   logic             wb_stb_i;
   logic             wb_cyc_i;
   bus_pkg::wb_dat_t wb_dat_o;
   logic             wb_ack_o;
   logic             cgen_st_status_i;
   logic             cgen_st_ld_i;
   logic             cgen_st_refmon_i;
   logic             cgen_sync_b_o;
   logic             cgen_ref_sel_o;
   logic             pps_i;

   logic [31:0]      lfsr = 32'd76;
   int               cycles = 0;    // rising edges since time zero
   int               xfer_cyc;      // edge count seen while the last transfer was sampled

   u1_core uut
   (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .wb_adr_i (wb_adr_i), .wb_dat_i (wb_dat_i), .wb_we_i (wb_we_i),
      .wb_stb_i (wb_stb_i), .wb_cyc_i (wb_cyc_i),
      .wb_dat_o (wb_dat_o), .wb_ack_o (wb_ack_o),
      .cgen_st_status_i (cgen_st_status_i), .cgen_st_ld_i (cgen_st_ld_i),
      .cgen_st_refmon_i (cgen_st_refmon_i),
      .cgen_sync_b_o (cgen_sync_b_o), .cgen_ref_sel_o (cgen_ref_sel_o),
      .pps_i (pps_i)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD/2) wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk)
      cycles <= cycles + 1;

   initial
   begin
      #(CLK_PERIOD * (N_XFERS * 20 + 200));
      $display("watchdog expired, the tests did not finish in time");
      $display("test failed");
      $fatal(1, "simulation stopped by the watchdog");
   end

   ////////////////////////////////////////////////////////////////////////
   // random numbers and address helpers

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'hB4BC_D35C;   // galois taps
      else
         return s >> 1;
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);            // one step per bit
         v    = {v[62:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic bus_pkg::wb_adr_t misc_adr(input logic [6:0] offs);
      return {4'h0, offs};
   endfunction

   function automatic bus_pkg::wb_adr_t rb_adr(input logic [3:0] word, input logic half);
      return {4'h7, 1'b0, word, half, 1'b0};
   endfunction

   function automatic bus_pkg::wb_adr_t set_adr(input logic [7:0] sa, input logic half);
      return {1'b1, sa, half, 1'b0};
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // checks and bus tasks, each transfer starts and ends at a falling edge

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("FAIL %s expected %0h actual %0h", name, exp, act);
         $display("test failed");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic end_xfer();
      wb_stb_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic wait_ack(input bus_pkg::wb_adr_t adr);
      int tries;
      tries = 0;
      #10;                                  // let the decode settle
      while (!wb_ack_o && tries < 4)
      begin
         @(negedge wb_clk);
         #10;
         tries++;
      end
      if (!wb_ack_o)
      begin
         $display("no ack from the slave at address %h", adr);
         $display("test failed");
         $fatal(1, "bus transfer never completed");
      end
      xfer_cyc = cycles;
   endtask

   task automatic bus_write(input bus_pkg::wb_adr_t adr, input bus_pkg::wb_dat_t dat);
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_we_i  = 1'b1;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      wait_ack(adr);
      @(posedge wb_clk);                    // write acts here
      @(negedge wb_clk);
      end_xfer();
   endtask

   task automatic bus_read(input bus_pkg::wb_adr_t adr, output bus_pkg::wb_dat_t dat);
      wb_adr_i = adr;
      wb_we_i  = 1'b0;
      wb_stb_i = 1'b1;
      wb_cyc_i = 1'b1;
      wait_ack(adr);
      dat = wb_dat_o;
      @(posedge wb_clk);
      @(negedge wb_clk);
      end_xfer();
   endtask

   // low half first, it latches the word for the high half
   task automatic read_word(input logic [3:0] word, output logic [31:0] val, output int c);
      bus_pkg::wb_dat_t lo;
      bus_pkg::wb_dat_t hi;
      bus_read(rb_adr(word, 1'b0), lo);
      c = xfer_cyc;
      bus_read(rb_adr(word, 1'b1), hi);
      val = {hi, lo};
   endtask

   task automatic idle(input int n);
      repeat (n) @(negedge wb_clk);
   endtask

   // setting strobe follows the high half by one edge, so wait one cycle
   task automatic write_setting(input logic [7:0] sa, input logic [31:0] v, output int c);
      bus_write(set_adr(sa, 1'b0), v[15:0]);
      bus_write(set_adr(sa, 1'b1), v[31:16]);
      c = xfer_cyc;
      idle(1);
   endtask

   ////////////////////////////////////////////////////////////////////////
   // tests

   initial
   begin
      logic [63:0]      load;
      logic [63:0]      exp;
      logic [31:0]      word;
      logic [31:0]      val;
      bus_pkg::wb_dat_t rd;
      bus_pkg::wb_dat_t ctrl;
      logic [6:0]       off;
      logic [3:0]       w;
      logic [2:0]       st;
      int               c;
      int               c_load;
      int               c_p;

      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      end_xfer();
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      pps_i            = 1'b0;
      repeat (5) @(posedge wb_clk);
      @(negedge wb_clk);
      wb_rst = 1'b0;

      // reset state
      check("reset sync_b", 64'd1, 64'(cgen_sync_b_o));
      check("reset ref_sel", 64'd1, 64'(cgen_ref_sel_o));
      bus_read(misc_adr(regmap_pkg::REG_TEST), rd);
      check("reset test reg", 64'd0, 64'(rd));
      read_word(regmap_pkg::RB_TEST32, val, c);
      check("reset test32", 64'd0, 64'(val));

      // misc registers
      repeat (N_ITER)
      begin
         ctrl = 16'(rand_bits(16));
         bus_write(misc_adr(regmap_pkg::REG_CGEN_CTRL), ctrl);
         bus_read(misc_adr(regmap_pkg::REG_CGEN_CTRL), rd);
         check("cgen ctrl", 64'(ctrl), 64'(rd));
         check("cgen sync_b", 64'(ctrl[1]), 64'(cgen_sync_b_o));
         check("cgen ref_sel", 64'(ctrl[0]), 64'(cgen_ref_sel_o));
         ctrl = 16'(rand_bits(16));
         bus_write(misc_adr(regmap_pkg::REG_TEST), ctrl);
         bus_read(misc_adr(regmap_pkg::REG_TEST), rd);
         check("test reg", 64'(ctrl), 64'(rd));
         st = 3'(rand_bits(3));
         {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = st;
         bus_read(misc_adr(regmap_pkg::REG_CGEN_ST), rd);
         check("cgen status", 64'(st), 64'(rd));
         off = 7'(rand_bits(7));
         while (off == 7'd4 || off == 7'd6 || off == 7'd8)
            off = 7'(rand_bits(7));
         bus_read(misc_adr(off), rd);
         check("unmapped misc offset", 64'h BEEF, 64'(rd));
      end

      // settings and readback
      repeat (N_ITER)
      begin
         word = 32'(rand_bits(32));
         write_setting(regmap_pkg::SR_REG_TEST32, word, c);
         read_word(regmap_pkg::RB_TEST32, val, c);
         check("test32 readback", 64'(word), 64'(val));
         w = 4'(rand_bits(4));
         while (w <= 4'd4 || w == 4'd6)
            w = 4'(rand_bits(4));
         read_word(w, val, c);
         check("unused readback word", 64'd0, 64'(val));
      end
      read_word(regmap_pkg::RB_COMPAT, val, c);
      check("compat number", 64'({16'(`COMPAT_MAJOR), 16'(`COMPAT_MINOR)}), 64'(val));

      // timer load, time after edge k is load + k - (load edge + 1) - 1
      repeat (N_ITER)
      begin
         load = rand_bits(64);
         write_setting(regmap_pkg::SR_TIME_HI, load[63:32], c);
         write_setting(regmap_pkg::SR_TIME_LO, load[31:0], c_load);
         read_word(regmap_pkg::RB_TIME_LO, val, c);
         exp = load + 64'(c - c_load - 2);
         check("time low word", 64'(exp[31:0]), 64'(val));
         read_word(regmap_pkg::RB_TIME_HI, val, c);
         exp = load + 64'(c - c_load - 2);
         check("time high word", 64'(exp[63:32]), 64'(val));
      end

      ////////////////////////////////////////////////////////////////////////
      // pps latch, captured three edges after the first sampling edge
      load = rand_bits(64);
      write_setting(regmap_pkg::SR_TIME_HI, load[63:32], c);
      write_setting(regmap_pkg::SR_TIME_LO, load[31:0], c_load);
      idle(2);
      c_p   = cycles;                       // next edge samples pps high
      pps_i = 1'b1;
      idle(8);
      exp = load + 64'(c_p + 1 - c_load);
      read_word(regmap_pkg::RB_PPS_LO, val, c);
      check("pps low word", 64'(exp[31:0]), 64'(val));
      read_word(regmap_pkg::RB_PPS_HI, val, c);
      check("pps high word", 64'(exp[63:32]), 64'(val));
      pps_i = 1'b0;
      idle(6);
      read_word(regmap_pkg::RB_PPS_LO, val, c);
      check("pps low word held", 64'(exp[31:0]), 64'(val));
      read_word(regmap_pkg::RB_PPS_HI, val, c);
      check("pps high word held", 64'(exp[63:32]), 64'(val));

      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
bus_pkg.sv
regmap_pkg.sv
wb_if.sv
wb_decode.sv
misc_regs.sv
settings_bus.sv
vita_timer.sv
readback_mux.sv
u1_core.sv
tb_u1_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary -f src.f --top-module tb_u1_core -o sim_tb

# the simulator exits nonzero on a failed check, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
exit 0
